/* src/fpu_pkg.sv */
package fpu_pkg;

    typedef enum logic [3:0] {
        FPU_OP_NONE         = 4'd0,
        FPU_OP_INT_TO_FLOAT = 4'd1,
        FPU_OP_FLOAT_TO_INT = 4'd2,
        FPU_OP_ADD          = 4'd3,
        FPU_OP_MULTIPLY     = 4'd4
    } fpu_op_e;

    // special value chosen by execute, packed by normalize
    typedef enum logic [1:0] {
        SPECIAL_NONE = 2'd0,
        SPECIAL_QNAN = 2'd1,
        SPECIAL_INF  = 2'd2,
        SPECIAL_ZERO = 2'd3
    } fpu_special_e;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [23:0] mantissa;   // hidden bit at [23], zero for flushed operands
        logic        is_zero;
        logic        is_special; // exponent 255
    } fpu_operand_t;

    localparam int FPU_BIAS = 127;

    localparam logic [31:0] FPU_QNAN    = 32'h7fc0_0000;
    localparam logic [31:0] FPU_INT_MAX = 32'h7fff_ffff;
    localparam logic [31:0] FPU_INT_MIN = 32'h8000_0000;

endpackage

/* src/fpu_stage_if.sv */
interface fpu_stage_if import fpu_pkg::*; ();

    logic              valid;
    fpu_op_e           op;
    fpu_operand_t      a;
    fpu_operand_t      b;
    logic [31:0]       raw;    // integer operand or raw a word
    logic [47:0]       wide;   // binary point sits below bit 46
    logic signed [9:0] exp;
    logic              sign;
    fpu_special_e      special_result;

    modport driver (
        output valid, op, a, b, raw, wide, exp, sign, special_result
    );

    modport receiver (
        input valid, op, a, b, raw, wide, exp, sign, special_result
    );

endinterface

/* src/fpu_unpack.sv */
module fpu_unpack import fpu_pkg::*; (
    input wire logic        clk,
    input wire logic        reset_i,

    input fpu_op_e          op_i,
    input wire logic [31:0] a_value_i,
    input wire logic [31:0] b_value_i,
    input wire logic        exec_strobe_i,

    fpu_stage_if.driver     out_o
    );

    fpu_operand_t a_split;
    fpu_operand_t b_split;
    logic         a_nan;
    logic         b_nan;
    fpu_special_e special_next;

    function automatic fpu_operand_t split_operand(input logic [31:0] value);
        fpu_operand_t f;
        f.sign       = value[31];
        f.exponent   = value[30:23];
        f.is_zero    = (value[30:23] == 8'd0);   // denormals flush here
        f.is_special = (value[30:23] == 8'hff);
        f.mantissa   = f.is_zero ? 24'd0 : {1'b1, value[22:0]};
        return f;
    endfunction

    assign a_split = split_operand(a_value_i);
    assign b_split = split_operand(b_value_i);
    assign a_nan   = a_split.is_special && (a_split.mantissa[22:0] != 23'd0);
    assign b_nan   = b_split.is_special && (b_split.mantissa[22:0] != 23'd0);

    // early nan detection, b only matters for two-operand ops
    always_comb begin
        case (op_i)
            FPU_OP_ADD, FPU_OP_MULTIPLY:
                special_next = (a_nan || b_nan) ? SPECIAL_QNAN : SPECIAL_NONE;
            FPU_OP_FLOAT_TO_INT:
                special_next = a_nan ? SPECIAL_QNAN : SPECIAL_NONE;
            default:
                special_next = SPECIAL_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_o.valid <= 1'b0;
        end else begin
            out_o.valid <= exec_strobe_i;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_strobe_i) begin
            out_o.op             <= op_i;
            out_o.a              <= a_split;
            out_o.b              <= b_split;
            out_o.raw            <= a_value_i;
            out_o.exp            <= $signed({2'b00, a_split.exponent})
                                    - $signed({2'b00, b_split.exponent});  // a minus b
            out_o.sign           <= a_value_i[31] ^ b_value_i[31];
            out_o.wide           <= '0;   // filled in by execute
            out_o.special_result <= special_next;
        end
    end

endmodule

/* src/fpu_execute.sv */
module fpu_execute import fpu_pkg::*; (
    input wire logic       clk,
    input wire logic       reset_i,

    fpu_stage_if.receiver  in_i,
    fpu_stage_if.driver    out_o
    );

    fpu_operand_t      larger_op;
    fpu_operand_t      smaller_op;
    logic              swap;
    logic [9:0]        exp_gap;
    logic [5:0]        shift_amt;
    logic [47:0]       larger_full;
    logic [47:0]       smaller_full;
    logic [47:0]       lost_mask;
    logic [47:0]       smaller_aligned;
    logic [31:0]       int_mag;
    logic              a_inf;
    logic              b_inf;
    logic [47:0]       wide_next;
    logic signed [9:0] exp_next;
    logic              sign_next;
    fpu_special_e      special_next;

    assign a_inf = in_i.a.is_special && (in_i.a.mantissa[22:0] == 23'd0);
    assign b_inf = in_i.b.is_special && (in_i.b.mantissa[22:0] == 23'd0);
    assign int_mag = in_i.raw[31] ? -in_i.raw : in_i.raw;

    // add alignment, larger magnitude first
    always_comb begin
        swap = (in_i.exp < 0) || (in_i.exp == 0 && in_i.a.mantissa < in_i.b.mantissa);
        larger_op  = swap ? in_i.b : in_i.a;
        smaller_op = swap ? in_i.a : in_i.b;
        exp_gap    = swap ? 10'(-in_i.exp) : 10'(in_i.exp);
        shift_amt  = (exp_gap > 10'd47) ? 6'd48 : exp_gap[5:0];

        larger_full     = {1'b0, larger_op.mantissa, 23'd0};
        smaller_full    = {1'b0, smaller_op.mantissa, 23'd0};
        lost_mask       = (48'd1 << shift_amt) - 48'd1;
        smaller_aligned = (smaller_full >> shift_amt)
                          | {47'd0, |(smaller_full & lost_mask)};  // sticky
    end

    always_comb begin
        wide_next    = '0;
        exp_next     = '0;
        sign_next    = 1'b0;
        special_next = SPECIAL_NONE;

        case (in_i.op)
            FPU_OP_INT_TO_FLOAT: begin
                wide_next = {16'd0, int_mag};
                exp_next  = 10'(FPU_BIAS + 46);
                sign_next = in_i.raw[31];
                if (int_mag == 32'd0) begin
                    special_next = SPECIAL_ZERO;
                    sign_next    = 1'b0;
                end
            end
            FPU_OP_FLOAT_TO_INT: begin
                wide_next    = {24'd0, in_i.a.mantissa};
                exp_next     = $signed({2'b00, in_i.a.exponent}) - 10'(FPU_BIAS + 23);
                sign_next    = in_i.a.sign;
                special_next = in_i.special_result;
            end
            FPU_OP_ADD: begin
                if (larger_op.sign == smaller_op.sign) begin
                    wide_next = larger_full + smaller_aligned;
                end else begin
                    wide_next = larger_full - smaller_aligned;
                end
                exp_next  = $signed({2'b00, larger_op.exponent});
                sign_next = larger_op.sign;

                if (in_i.special_result == SPECIAL_QNAN) begin
                    special_next = SPECIAL_QNAN;
                end else if (a_inf && b_inf && (in_i.a.sign != in_i.b.sign)) begin
                    special_next = SPECIAL_QNAN;   // inf - inf
                end else if (a_inf || b_inf) begin
                    special_next = SPECIAL_INF;
                    sign_next    = a_inf ? in_i.a.sign : in_i.b.sign;
                end else if (wide_next == 48'd0) begin
                    special_next = SPECIAL_ZERO;
                    sign_next    = in_i.a.sign & in_i.b.sign;  // -0 only for -0 + -0
                end
            end
            FPU_OP_MULTIPLY: begin
                wide_next = in_i.a.mantissa * in_i.b.mantissa;
                exp_next  = $signed({2'b00, in_i.a.exponent})
                            + $signed({2'b00, in_i.b.exponent}) - 10'(FPU_BIAS);
                sign_next = in_i.sign;

                if (in_i.special_result == SPECIAL_QNAN) begin
                    special_next = SPECIAL_QNAN;
                end else if (a_inf || b_inf) begin
                    special_next = (in_i.a.is_zero || in_i.b.is_zero) ? SPECIAL_QNAN
                                                                      : SPECIAL_INF;
                end else if (in_i.a.is_zero || in_i.b.is_zero) begin
                    special_next = SPECIAL_ZERO;
                end
            end
            default: begin
                special_next = SPECIAL_ZERO;   // unknown op completes as +0
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_o.valid <= 1'b0;
        end else begin
            out_o.valid <= in_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_i.valid) begin
            out_o.op             <= in_i.op;
            out_o.a              <= in_i.a;
            out_o.b              <= in_i.b;
            out_o.raw            <= in_i.raw;
            out_o.wide           <= wide_next;
            out_o.exp            <= exp_next;
            out_o.sign           <= sign_next;
            out_o.special_result <= special_next;
        end
    end

endmodule

/* src/fpu_normalize.sv */
module fpu_normalize import fpu_pkg::*; (
    input wire logic        clk,
    input wire logic        reset_i,

    fpu_stage_if.receiver   in_i,

    output logic            norm_valid_o,
    output logic     [31:0] norm_value_o
    );

    logic [5:0]         lead;
    logic [47:0]        shifted;
    logic signed [10:0] exp_adj;
    logic [4:0]         rshift;
    logic [31:0]        int_mag;
    logic [31:0]        value_next;

    function automatic logic [5:0] leading_one(input logic [47:0] v);
        logic [5:0] pos;
        pos = 6'd0;
        for (int i = 0; i < 48; i++) begin
            if (v[i]) begin
                pos = 6'(i);
            end
        end
        return pos;
    endfunction

    always_comb begin
        lead    = leading_one(in_i.wide);
        shifted = in_i.wide << (6'd47 - lead);   // leading one lands on bit 47
        exp_adj = in_i.exp + $signed({5'd0, lead}) - 11'sd46;

        // float to int, exp is a signed left shift of the 24-bit mantissa
        rshift  = 5'(-in_i.exp);
        int_mag = 32'd0;
        if (in_i.exp >= 10'sd0) begin
            int_mag = {8'd0, in_i.wide[23:0]} << in_i.exp[2:0];
        end else if (in_i.exp > -10'sd24) begin
            int_mag = {8'd0, in_i.wide[23:0]} >> rshift;
        end
    end

    always_comb begin
        if (in_i.op == FPU_OP_FLOAT_TO_INT) begin
            if (in_i.special_result == SPECIAL_QNAN) begin
                value_next = FPU_INT_MIN;
            end else if (in_i.exp >= 10'sd8) begin
                value_next = in_i.sign ? FPU_INT_MIN : FPU_INT_MAX;  // saturate
            end else begin
                value_next = in_i.sign ? -int_mag : int_mag;
            end
        end else begin
            case (in_i.special_result)
                SPECIAL_QNAN:
                    value_next = FPU_QNAN;
                SPECIAL_INF:
                    value_next = {in_i.sign, 8'hff, 23'd0};
                SPECIAL_ZERO:
                    value_next = {in_i.sign, 31'd0};
                default: begin
                    if (exp_adj >= 11'sd255) begin
                        value_next = {in_i.sign, 8'hff, 23'd0};   // overflow
                    end else if (exp_adj <= 11'sd0 || in_i.wide == 48'd0) begin
                        value_next = {in_i.sign, 31'd0};          // flush underflow
                    end else begin
                        value_next = {in_i.sign, exp_adj[7:0], shifted[46:24]};
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            norm_valid_o <= 1'b0;
        end else begin
            norm_valid_o <= in_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_i.valid) begin
            norm_value_o <= value_next;
        end
    end

endmodule

/* src/fpu_result_buffer.sv */
module fpu_result_buffer #(
    parameter int OUT_DEPTH      = 4,
    parameter int RESULT_CREDITS = 2
    ) (
    input wire logic        clk,
    input wire logic        reset_i,

    input wire logic        norm_valid_i,
    input wire logic [31:0] norm_value_i,

    input wire logic        result_credit_i,
    output logic     [31:0] z_value_o,
    output logic            done_strobe_o,
    output logic            issue_credit_o
    );

    localparam int PTR_W    = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int CNT_W    = $clog2(OUT_DEPTH + 1);
    localparam int CREDIT_W = $clog2(RESULT_CREDITS + 1);

    logic [31:0]         mem [OUT_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic [CREDIT_W-1:0] credit_cnt;
    logic                fifo_empty;
    logic                head_valid;
    logic [31:0]         head_value;
    logic                pop;
    logic                fifo_read;
    logic                fifo_write;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(OUT_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // an empty FIFO lets the incoming result straight through
    assign fifo_empty = (count == '0);
    assign head_valid = !fifo_empty || norm_valid_i;
    assign head_value = fifo_empty ? norm_value_i : mem[rd_ptr];
    assign pop        = head_valid && (credit_cnt != '0);
    assign fifo_read  = pop && !fifo_empty;
    assign fifo_write = norm_valid_i && !(pop && fifo_empty);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            credit_cnt     <= CREDIT_W'(RESULT_CREDITS);
            done_strobe_o  <= 1'b0;
            issue_credit_o <= 1'b0;
        end else begin
            if (fifo_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (fifo_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count          <= count + CNT_W'(fifo_write) - CNT_W'(fifo_read);
            credit_cnt     <= credit_cnt + CREDIT_W'(result_credit_i) - CREDIT_W'(pop);
            done_strobe_o  <= pop;
            issue_credit_o <= pop;   // entry released, issuer may send another
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_write) begin
            mem[wr_ptr] <= norm_value_i;
        end
        if (pop) begin
            z_value_o <= head_value;
        end
    end

    // issue credits bound the number of results in flight
    a_no_overflow: assert property (@(posedge clk) disable iff (reset_i)
        (fifo_write && !fifo_read) |-> (count < CNT_W'(OUT_DEPTH)));

    // consumer returned more credits than it owns
    a_credit_bound: assert property (@(posedge clk) disable iff (reset_i)
        credit_cnt <= CREDIT_W'(RESULT_CREDITS));

    a_strobe_has_credit: assert property (@(posedge clk) disable iff (reset_i)
        done_strobe_o |-> ($past(credit_cnt) != '0));

endmodule

/* src/fpu.sv */
module fpu import fpu_pkg::*; #(
    parameter int OUT_DEPTH      = 4,
    parameter int RESULT_CREDITS = 2
    ) (
    input wire logic        clk,
    input wire logic        reset_i,

    input wire logic [3:0]  op_i,
    input wire logic [31:0] a_value_i,
    input wire logic [31:0] b_value_i,
    input wire logic        exec_strobe_i,
    output logic            issue_credit_o,

    output logic     [31:0] z_value_o,
    output logic            done_strobe_o,
    input wire logic        result_credit_i
    );

    logic        norm_valid;
    logic [31:0] norm_value;

    fpu_stage_if unpack_to_exec();
    fpu_stage_if exec_to_norm();

    fpu_unpack u_unpack(
        .clk(clk),
        .reset_i(reset_i),
        .op_i(fpu_op_e'(op_i)),    // unknown codes pass through as is
        .a_value_i(a_value_i),
        .b_value_i(b_value_i),
        .exec_strobe_i(exec_strobe_i),
        .out_o(unpack_to_exec.driver)
    );

    fpu_execute u_execute(
        .clk(clk),
        .reset_i(reset_i),
        .in_i(unpack_to_exec.receiver),
        .out_o(exec_to_norm.driver)
    );

    fpu_normalize u_normalize(
        .clk(clk),
        .reset_i(reset_i),
        .in_i(exec_to_norm.receiver),
        .norm_valid_o(norm_valid),
        .norm_value_o(norm_value)
    );

    fpu_result_buffer #(
        .OUT_DEPTH(OUT_DEPTH),
        .RESULT_CREDITS(RESULT_CREDITS)
    ) u_result_buffer (
        .clk(clk),
        .reset_i(reset_i),
        .norm_valid_i(norm_valid),
        .norm_value_i(norm_value),
        .result_credit_i(result_credit_i),
        .z_value_o(z_value_o),
        .done_strobe_o(done_strobe_o),
        .issue_credit_o(issue_credit_o)
    );

endmodule

/* testbench/fpu_tb.sv */
module fpu_tb import fpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        reset_i;
    logic [3:0]  op_i;
    logic [31:0] a_value_i;
    logic [31:0] b_value_i;
    logic        exec_strobe_i;
    logic        issue_credit_o;
    logic [31:0] z_value_o;
    logic        done_strobe_o;
    logic        result_credit_i;

    logic [3:0]  req_op[$];
    logic [31:0] req_a[$];
    logic [31:0] req_b[$];
    logic [31:0] exp_q[$];

    int seed = 32'h78e2_8642;
    int errors = 0;
    int timeouts = 0;
    int cycle = 0;
    int issue_credits = 4;     // starts at OUT_DEPTH
    int pending_credits = 0;   // consumer credits not yet returned
    int results_seen = 0;
    int last_issue_cycle = 0;
    int last_done_cycle = 0;
    bit hold_credits = 1'b0;

    fpu u_fpu (
        .clk(clk),
        .reset_i(reset_i),
        .op_i(op_i),
        .a_value_i(a_value_i),
        .b_value_i(b_value_i),
        .exec_strobe_i(exec_strobe_i),
        .issue_credit_o(issue_credit_o),
        .z_value_o(z_value_o),
        .done_strobe_o(done_strobe_o),
        .result_credit_i(result_credit_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // issuer and consumer models act on the falling edge
    always @(negedge clk) begin
        logic [31:0] expected;
        if (!reset_i) begin
            // an entry is released exactly when its result leaves
            assert (issue_credit_o == done_strobe_o) else begin
                errors++;
                $display("[FAIL] issue_credit_o expected %h actual %h",
                         done_strobe_o, issue_credit_o);
            end
            if (issue_credit_o) issue_credits++;
            if (done_strobe_o) begin
                last_done_cycle = cycle;
                results_seen++;
                pending_credits++;
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("a result arrived with no operation outstanding");
                end
                if (exp_q.size() > 0) begin
                    expected = exp_q.pop_front();
                    assert (z_value_o == expected) else begin
                        errors++;
                        $display("[FAIL] z_value_o expected %h actual %h", expected, z_value_o);
                    end
                end
            end
            if (!hold_credits && pending_credits > 0) begin
                result_credit_i = 1'b1;
                pending_credits--;
            end else begin
                result_credit_i = 1'b0;
            end
            if (req_op.size() > 0 && issue_credits > 0) begin   // never strobe without credit
                op_i = req_op.pop_front();
                a_value_i = req_a.pop_front();
                b_value_i = req_b.pop_front();
                exec_strobe_i = 1'b1;
                issue_credits--;
                last_issue_cycle = cycle;
            end else begin
                exec_strobe_i = 1'b0;
            end
        end
    end

    task automatic queue_op(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] expected);
        req_op.push_back(op);
        req_a.push_back(a);
        req_b.push_back(b);
        exp_q.push_back(expected);
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while ((req_op.size() > 0 || exp_q.size() > 0) && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (req_op.size() > 0 || exp_q.size() > 0) begin
            timeouts++;
            $display("timeout while waiting for %s to finish", what);
            req_op.delete();
            req_a.delete();
            req_b.delete();
            exp_q.delete();
        end
    endtask

    task automatic wait_issued(input string what);
        int n;
        n = 0;
        while (req_op.size() > 0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (req_op.size() > 0) begin
            timeouts++;
            $display("timeout while issuing the operations of %s", what);
        end
    endtask

    // truncating conversion straight from the IEEE field layout
    function automatic logic [31:0] int_to_float_rtz(input logic [31:0] v);
        logic [31:0] mag;
        logic [31:0] frac;
        int          msb;
        if (v == 32'd0) return 32'd0;
        mag = v[31] ? -v : v;
        msb = 0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i]) msb = i;
        end
        frac = (msb >= 23) ? (mag >> (msb - 23)) : (mag << (23 - msb));
        return {v[31], 8'(127 + msb), frac[22:0]};
    endfunction

    task automatic test_convert();
        queue_op(FPU_OP_INT_TO_FLOAT, 32'd0, 32'd0, 32'h0000_0000);
        queue_op(FPU_OP_INT_TO_FLOAT, 32'd1, 32'd0, 32'h3f80_0000);
        queue_op(FPU_OP_INT_TO_FLOAT, -32'sd3, 32'd0, 32'hc040_0000);
        queue_op(FPU_OP_INT_TO_FLOAT, 32'd1000, 32'd0, 32'h447a_0000);
        queue_op(FPU_OP_INT_TO_FLOAT, 32'd16777217, 32'd0, 32'h4b80_0000);  // low bit lost
        queue_op(FPU_OP_FLOAT_TO_INT, 32'h4070_0000, 32'd0, 32'd3);
        queue_op(FPU_OP_FLOAT_TO_INT, 32'hc020_0000, 32'd0, 32'hffff_fffe);
        queue_op(FPU_OP_FLOAT_TO_INT, 32'h5015_02f9, 32'd0, FPU_INT_MAX);    // 1e10
        queue_op(FPU_OP_FLOAT_TO_INT, 32'h7fc0_0000, 32'd0, FPU_INT_MIN);
        wait_drained("test_convert");
    endtask

    task automatic test_add();
        queue_op(FPU_OP_ADD, 32'h3fc0_0000, 32'h4010_0000, 32'h4070_0000);  // 1.5 + 2.25
        queue_op(FPU_OP_ADD, 32'h3f80_0000, 32'hbf80_0000, 32'h0000_0000);
        queue_op(FPU_OP_ADD, 32'h4000_0000, 32'hbf00_0000, 32'h3fc0_0000);  // 2.0 - 0.5
        queue_op(FPU_OP_ADD, 32'h3f00_0000, 32'h3e80_0000, 32'h3f40_0000);
        queue_op(FPU_OP_ADD, 32'h7fc0_0000, 32'h3f80_0000, FPU_QNAN);
        queue_op(FPU_OP_ADD, 32'h7f80_0000, 32'h3f80_0000, 32'h7f80_0000);
        wait_drained("test_add");
    endtask

    task automatic test_multiply();
        queue_op(FPU_OP_MULTIPLY, 32'h3fc0_0000, 32'h4000_0000, 32'h4040_0000);
        queue_op(FPU_OP_MULTIPLY, 32'hbf00_0000, 32'h4080_0000, 32'hc000_0000);
        queue_op(FPU_OP_MULTIPLY, 32'h4040_0000, 32'h8000_0000, 32'h8000_0000);
        queue_op(FPU_OP_MULTIPLY, 32'h7f00_0000, 32'h7f00_0000, 32'h7f80_0000);
        queue_op(FPU_OP_MULTIPLY, 32'h0040_0000, 32'hc000_0000, 32'h8000_0000); // denormal
        wait_drained("test_multiply");
    endtask

    task automatic test_latency();
        wait_drained("pipeline before test_latency");
        queue_op(FPU_OP_ADD, 32'h3f80_0000, 32'h3f80_0000, 32'h4000_0000);
        wait_drained("test_latency");
        assert (last_done_cycle - last_issue_cycle == 4) else begin
            errors++;
            $display("add took %0d cycles from strobe to result instead of 4",
                     last_done_cycle - last_issue_cycle);
        end
    endtask

    task automatic test_backpressure();
        logic [31:0] v;
        int          base;
        wait_drained("pipeline before test_backpressure");
        hold_credits = 1'b1;
        base = results_seen;
        for (int i = 0; i < 6; i++) begin
            v = $random(seed);
            queue_op(FPU_OP_INT_TO_FLOAT, v, 32'd0, int_to_float_rtz(v));
        end
        wait_issued("test_backpressure");
        repeat (12) @(negedge clk);   // well past the 4-cycle latency
        assert (results_seen - base == 2) else begin
            errors++;
            $display("expected 2 results while credits were held, saw %0d", results_seen - base);
        end
        assert (!done_strobe_o) else begin
            errors++;
            $display("[FAIL] done_strobe_o expected %h actual %h", 1'b0, done_strobe_o);
        end
        assert (issue_credits == 0) else begin
            errors++;
            $display("[FAIL] issue_credits expected %h actual %h", 0, issue_credits);
        end
        hold_credits = 1'b0;
        wait_drained("test_backpressure");
    endtask

    task automatic test_bad_opcode();
        queue_op(FPU_OP_ADD, 32'h3fc0_0000, 32'h4010_0000, 32'h4070_0000);
        queue_op(4'd9, 32'h3f80_0000, 32'h4000_0000, 32'h0000_0000);
        queue_op(FPU_OP_INT_TO_FLOAT, 32'd1, 32'd0, 32'h3f80_0000);
        wait_drained("test_bad_opcode");
    endtask

    initial begin
        reset_i = 1'b1;
        op_i = 4'd0;
        a_value_i = 32'd0;
        b_value_i = 32'd0;
        exec_strobe_i = 1'b0;
        result_credit_i = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        test_convert();
        test_add();
        test_multiply();
        test_latency();
        test_backpressure();
        test_bad_opcode();

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
src/fpu_pkg.sv
src/fpu_stage_if.sv
src/fpu_unpack.sv
src/fpu_execute.sv
src/fpu_normalize.sv
src/fpu_result_buffer.sv
src/fpu.sv
testbench/fpu_tb.sv

/* Makefile */
.PHONY: run clean

# rebuilt only when a listed source or the list itself changes
obj_dir/Vfpu_tb: files.f $(shell cat files.f)
	verilator --binary --timing --assert -Wno-fatal --top-module fpu_tb -f files.f

run: obj_dir/Vfpu_tb
	@out="$$(./obj_dir/Vfpu_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
